// File: logic/rtc_bus_pkg.sv
package rtc_bus_pkg;

  ///////////////////////////////
  // Host side request
  ///////////////////////////////

  // One bus write; write is a level, held while the request stands
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
    logic       write;
  } rtc_req_t;

  ///////////////////////////////
  // Chip side pins
  ///////////////////////////////

  // Multiplexed address/data bus, strobes active low except ale
  typedef struct packed {
    logic [7:0] ad;
    logic       ale;
    logic       cs_n;
    logic       wr_n;
    logic       rd_n;
  } rtc_pins_t;

  // Bus parked: chip deselected, no strobes, ad driven low
  localparam rtc_pins_t RTC_PINS_IDLE = '{
    ad:   8'h00,
    ale:  1'b0,
    cs_n: 1'b1,
    wr_n: 1'b1,
    rd_n: 1'b1
  };

endpackage

// File: logic/rtc_map_pkg.sv
package rtc_map_pkg;

  ///////////////////////////////
  // Timekeeping registers
  ///////////////////////////////

  localparam logic [7:0] RTC_REG_SECONDS = 8'h21;
  localparam logic [7:0] RTC_REG_MINUTES = 8'h22;
  localparam logic [7:0] RTC_REG_HOURS   = 8'h23;
  localparam logic [7:0] RTC_REG_DATE    = 8'h24;
  localparam logic [7:0] RTC_REG_MONTH   = 8'h25;
  localparam logic [7:0] RTC_REG_YEAR    = 8'h26;

  ///////////////////////////////
  // Transfer command
  ///////////////////////////////

  // Writing F0 to F0 copies the user registers into the
  // running time counters, so every update ends with it
  localparam logic [7:0] RTC_XFER_ADDR = 8'hf0;
  localparam logic [7:0] RTC_XFER_DATA = 8'hf0;

endpackage

// File: logic/rtc_write_seq.sv
`timescale 1ns/100ps

module rtc_write_seq (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [7:0]            addr,
  input  logic [7:0]            data,
  input  logic                  cycle_done,
  output rtc_bus_pkg::rtc_req_t req,
  output logic                  busy,
  output logic                  finished
);

  import rtc_map_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE   = 2'b00,
    S_WRITE  = 2'b01,
    S_XFER   = 2'b10,
    S_FINISH = 2'b11
  } state_t;

  state_t state;
  state_t next_state;

  ///////////////////////////////
  // Next state
  ///////////////////////////////

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE: begin
        // Outputs lag by a clock, so busy is still low here
        if (start) begin
          next_state = S_WRITE;
        end
      end
      S_WRITE: begin
        if (cycle_done) begin
          next_state = S_XFER;
        end
      end
      S_XFER: begin
        if (cycle_done) begin
          next_state = S_FINISH;
        end
      end
      S_FINISH: begin
        next_state = S_IDLE;
      end
      default: begin
        next_state = S_IDLE;
      end
    endcase
  end

  ///////////////////////////////
  // State and registered outputs
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= S_IDLE;
      req      <= '0;
      busy     <= 1'b0;
      finished <= 1'b0;
    end else begin
      state <= next_state;
      case (state)
        S_WRITE: begin
          // Host write, addr/data resampled each clock
          req.addr  <= addr;
          req.data  <= data;
          req.write <= 1'b1;
          busy      <= 1'b1;
          finished  <= 1'b0;
        end
        S_XFER: begin
          req.addr  <= RTC_XFER_ADDR;
          req.data  <= RTC_XFER_DATA;
          req.write <= 1'b1;
          busy      <= 1'b1;
          finished  <= 1'b0;
        end
        S_FINISH: begin
          req      <= '0;
          busy     <= 1'b0;
          finished <= 1'b1;
        end
        default: begin
          req      <= '0;
          busy     <= 1'b0;
          finished <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: logic/rtc_bus_cycle.sv
`timescale 1ns/100ps

module rtc_bus_cycle #(
  parameter int PHASE_CYCLES = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  rtc_bus_pkg::rtc_req_t  req,
  output logic                   cycle_done,
  output rtc_bus_pkg::rtc_pins_t pins
);

  import rtc_bus_pkg::*;

  // Counter also spans the two turnaround clocks
  localparam int CNT_W = $clog2(PHASE_CYCLES + 2);

  localparam logic [CNT_W-1:0] PHASE_LAST = CNT_W'(PHASE_CYCLES - 1);
  localparam logic [CNT_W-1:0] TURN_LAST  = CNT_W'(1);

  typedef enum logic [2:0] {
    P_IDLE  = 3'd0,
    P_ALE   = 3'd1,
    P_WRITE = 3'd2,
    P_HOLD  = 3'd3,
    P_TURN  = 3'd4
  } phase_t;

  phase_t           phase;
  logic [CNT_W-1:0] cnt;
  logic [7:0]       addr_q;
  logic [7:0]       data_q;
  logic             phase_end;

  assign phase_end = (cnt == PHASE_LAST);

  ///////////////////////////////
  // Phase sequencing
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= P_IDLE;
      cnt   <= '0;
    end else begin
      case (phase)
        P_IDLE: begin
          cnt <= '0;
          if (req.write) begin
            phase <= P_ALE;
          end
        end
        P_ALE, P_WRITE, P_HOLD: begin
          if (phase_end) begin
            cnt   <= '0;
            phase <= phase_t'(phase + 3'd1);
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        P_TURN: begin
          // req is still the old one here, ignore it
          if (cnt == TURN_LAST) begin
            cnt   <= '0;
            phase <= P_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          cnt   <= '0;
          phase <= P_IDLE;
        end
      endcase
    end
  end

  // Address and data captured when a cycle starts
  always_ff @(posedge clk) begin
    if (phase == P_IDLE && req.write) begin
      addr_q <= req.addr;
      data_q <= req.data;
    end
  end

  ///////////////////////////////
  // Pin waveform
  ///////////////////////////////

  always_comb begin
    pins = RTC_PINS_IDLE;
    case (phase)
      P_ALE: begin
        pins.cs_n = 1'b0;
        pins.ale  = 1'b1;
        pins.ad   = addr_q;
      end
      P_WRITE: begin
        pins.cs_n = 1'b0;
        pins.wr_n = 1'b0;
        pins.ad   = data_q;
      end
      P_HOLD: begin
        pins.cs_n = 1'b0;
        pins.ad   = data_q;
      end
      default: begin
        pins = RTC_PINS_IDLE;
      end
    endcase
  end

  assign cycle_done = (phase == P_HOLD) && phase_end;

endmodule

// File: logic/rtc_write_port.sv
`timescale 1ns/100ps

module rtc_write_port #(
  parameter int PHASE_CYCLES = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic [7:0]             addr,
  input  logic [7:0]             data,
  output logic                   busy,
  output logic                   finished,
  output rtc_bus_pkg::rtc_pins_t pins
);

  import rtc_bus_pkg::*;

  rtc_req_t req;
  logic     cycle_done;

  // Write then transfer command, one request at a time
  rtc_write_seq rtc_write_seq_inst (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .addr       (addr),
    .data       (data),
    .cycle_done (cycle_done),
    .req        (req),
    .busy       (busy),
    .finished   (finished)
  );

  rtc_bus_cycle #(
    .PHASE_CYCLES (PHASE_CYCLES)
  ) rtc_bus_cycle_inst (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .cycle_done (cycle_done),
    .pins       (pins)
  );

endmodule

// File: tb/rtc_write_port_checker.sv
`timescale 1ns/100ps

module rtc_write_port_checker (
  input logic                   clk,
  input logic                   reset,
  input logic                   finished,
  input rtc_bus_pkg::rtc_pins_t pins
);

  //////////////////////////////
  // Pin protocol
  //////////////////////////////

  // Address latch and write strobe never overlap
  ale_wr_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(pins.ale && !pins.wr_n)
  ) else $error("ale and wr_n active in the same cycle");

  // Write strobe only with the chip selected
  wr_needs_cs: assert property (
    @(posedge clk) disable iff (reset) !pins.wr_n |-> !pins.cs_n
  ) else $error("wr_n low while cs_n high");

  rd_inactive: assert property (
    @(posedge clk) disable iff (reset) pins.rd_n
  ) else $error("rd_n driven low");

  // Completion is a single clock pulse
  finished_pulse: assert property (
    @(posedge clk) disable iff (reset) finished |=> !finished
  ) else $error("finished high for more than one clock");

endmodule

bind rtc_write_port rtc_write_port_checker rtc_write_port_checker_inst (
  .clk      (clk),
  .reset    (reset),
  .finished (finished),
  .pins     (pins)
);

// File: tb/rtc_write_port_tb.sv
`timescale 1ns/100ps

module rtc_write_port_tb #(
  parameter int PHASE_CYCLES = 4
);

  import rtc_bus_pkg::*;
  import rtc_map_pkg::*;

  localparam int ROWS        = 12;
  localparam int OP_CYCLES   = 2 * (3 * PHASE_CYCLES + 2) + 8;
  localparam int CYCLE_LIMIT = ROWS * OP_CYCLES * 2;

  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
    logic       extra_start;
  } row_t;

  logic       clk;
  logic       reset;
  logic       start;
  logic [7:0] addr;
  logic [7:0] data;
  logic       busy;
  logic       finished;
  rtc_pins_t  pins;

  row_t       stim_rows [ROWS];
  logic [7:0] bus_addr [$];
  logic [7:0] bus_data [$];
  logic [7:0] ale_addr      = 8'h00;
  rtc_pins_t  prev_pins     = RTC_PINS_IDLE;
  int         finish_pulses = 0;
  int         cycle_count   = 0;
  int         error_count   = 0;
  int         test_errors   = 0;
  int         test_count    = 0;

  rtc_write_port #(
    .PHASE_CYCLES (PHASE_CYCLES)
  ) rtc_write_port_inst (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .addr     (addr),
    .data     (data),
    .busy     (busy),
    .finished (finished),
    .pins     (pins)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Limit scales with the bus phase length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run timed out after %0d clock cycles", cycle_count);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////
  // Pin monitor
  //////////////////////////////

  // Edges found by comparing with the previous falling-edge sample
  always @(negedge clk) begin
    if (!reset) begin
      if (prev_pins.ale && !pins.ale) begin
        ale_addr = prev_pins.ad;
      end
      if (!prev_pins.wr_n && pins.wr_n) begin
        bus_addr.push_back(ale_addr);
        bus_data.push_back(prev_pins.ad);
      end
      if (finished) begin
        finish_pulses = finish_pulses + 1;
      end
    end
    prev_pins = pins;
  end

  //////////////////////////////
  // Check helpers
  //////////////////////////////

  task automatic verify_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic compare_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic note_problem(input string msg);
    $display("Problem: %s", msg);
    test_errors++;
    error_count++;
  endtask

  task automatic close_test(input string what);
    test_count++;
    if (test_errors == 0) begin
      $display("Test %0d %s: ok", test_count, what);
    end else begin
      $display("Test %0d %s: %0d errors", test_count, what, test_errors);
    end
    test_errors = 0;
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  task automatic fill_stimulus();
    stim_rows[0] = '{RTC_REG_SECONDS, 8'h45, 1'b0};
    stim_rows[1] = '{RTC_REG_MINUTES, 8'h30, 1'b1};
    stim_rows[2] = '{RTC_REG_HOURS,   8'h17, 1'b0};
    stim_rows[3] = '{RTC_REG_DATE,    8'h28, 1'b1};
    stim_rows[4] = '{RTC_REG_MONTH,   8'h09, 1'b0};
    stim_rows[5] = '{RTC_REG_YEAR,    8'h99, 1'b1};
    for (int i = 6; i < ROWS; i++) begin
      stim_rows[i].addr        = 8'($urandom());
      stim_rows[i].data        = 8'($urandom());
      stim_rows[i].extra_start = 1'($urandom_range(1, 0));
    end
  endtask

  task automatic inspect_reset();
    verify_bit("ale", pins.ale, 1'b0);
    verify_bit("cs_n", pins.cs_n, 1'b1);
    verify_bit("wr_n", pins.wr_n, 1'b1);
    verify_bit("rd_n", pins.rd_n, 1'b1);
    compare_byte("ad", pins.ad, 8'h00);
    verify_bit("busy", busy, 1'b0);
    verify_bit("finished", finished, 1'b0);
    close_test("reset state");
  endtask

  task automatic apply_row(input int idx);
    row_t row;
    int   base;
    int   pulses_before;
    int   waits;
    int   cycles;
    row           = stim_rows[idx];
    base          = bus_addr.size();
    pulses_before = finish_pulses;
    start = 1'b1;
    addr  = row.addr;
    data  = row.data;
    @(posedge clk);
    #2;
    start = 1'b0;
    waits = 1;
    while (!busy) begin
      @(posedge clk);
      #2;
      waits++;
    end
    if (waits != 2) begin
      note_problem($sformatf("busy rose %0d clocks after start, expected 2", waits));
    end
    // Host lets go of the bus inputs once busy is up
    addr   = ~row.addr;
    data   = ~row.data;
    cycles = 0;
    while (!finished) begin
      // Extra start lands while the transfer command is pending
      start = row.extra_start && (cycles == 4 * PHASE_CYCLES);
      verify_bit("busy", busy, 1'b1);
      @(posedge clk);
      #2;
      cycles++;
    end
    start = 1'b0;
    verify_bit("busy", busy, 1'b0);
    if (bus_addr.size() != base + 2) begin
      note_problem($sformatf("%0d bus writes before finished, expected 2",
                             bus_addr.size() - base));
    end else begin
      compare_byte("write 1 ad (address)", bus_addr[base], row.addr);
      compare_byte("write 1 ad (data)", bus_data[base], row.data);
      compare_byte("write 2 ad (address)", bus_addr[base + 1], RTC_XFER_ADDR);
      compare_byte("write 2 ad (data)", bus_data[base + 1], RTC_XFER_DATA);
    end
    repeat (4) begin
      @(posedge clk);
      #2;
      verify_bit("busy", busy, 1'b0);
      verify_bit("finished", finished, 1'b0);
    end
    verify_bit("cs_n", pins.cs_n, 1'b1);
    if (finish_pulses - pulses_before != 1) begin
      note_problem($sformatf("finished pulsed %0d times in one operation",
                             finish_pulses - pulses_before));
    end
    if (bus_addr.size() != base + 2) begin
      note_problem("extra bus writes appeared after finished");
    end
    close_test($sformatf("row %0d addr 0x%02h data 0x%02h extra start %0d",
                         idx, row.addr, row.data, row.extra_start));
  endtask

  // Whole recorded bus log against the table
  task automatic inspect_sequence();
    if (bus_addr.size() != 2 * ROWS) begin
      note_problem($sformatf("recorded %0d bus writes, expected %0d",
                             bus_addr.size(), 2 * ROWS));
    end else begin
      for (int i = 0; i < ROWS; i++) begin
        compare_byte("log ad (address)", bus_addr[2 * i], stim_rows[i].addr);
        compare_byte("log ad (data)", bus_data[2 * i], stim_rows[i].data);
        compare_byte("log ad (xfer address)", bus_addr[2 * i + 1], RTC_XFER_ADDR);
        compare_byte("log ad (xfer data)", bus_data[2 * i + 1], RTC_XFER_DATA);
      end
    end
    close_test($sformatf("full bus sequence, PHASE_CYCLES %0d", PHASE_CYCLES));
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    reset = 1'b1;
    start = 1'b0;
    addr  = 8'h00;
    data  = 8'h00;
    void'($urandom(32'h44c6_edba));
    fill_stimulus();
    repeat (5) @(posedge clk);
    #2;
    inspect_reset();
    reset = 1'b0;
    for (int i = 0; i < ROWS; i++) begin
      apply_row(i);
    end
    inspect_sequence();
    $display("Summary: %0d tests, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: rtc_write_port.f
logic/rtc_bus_pkg.sv
logic/rtc_map_pkg.sv
logic/rtc_write_seq.sv
logic/rtc_bus_cycle.sv
logic/rtc_write_port.sv
tb/rtc_write_port_checker.sv
tb/rtc_write_port_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run once per bus phase length, one log each
cd "$(dirname "$0")" || exit 1

status=0
for phase in 2 4; do
  log="sim_phase${phase}.log"
  mdir="obj_dir_phase${phase}"
  rm -f "${log}"
  verilator --binary --timing --assert -Wno-fatal \
    --top-module rtc_write_port_tb -GPHASE_CYCLES=${phase} \
    --Mdir "${mdir}" -f rtc_write_port.f \
    && "./${mdir}/Vrtc_write_port_tb" > "${log}" 2>&1 \
    || { echo "PHASE_CYCLES=${phase}: build or run error"; status=1; }
  [ -f "${log}" ] && cat "${log}"
  grep -q "sim failed" "${log}" 2>/dev/null \
    && { echo "PHASE_CYCLES=${phase}: failure reported"; status=1; }
  grep -q "sim passed" "${log}" 2>/dev/null \
    || { echo "PHASE_CYCLES=${phase}: run did not complete"; status=1; }
done
exit ${status}
